//--- list.f
common/dcache_pkg.sv
data_cache/cache_miss_ctrl.sv
data_cache/data_cache.sv
src/main_memory.sv
src/cache_subsystem.sv
verification/tb_cache_subsystem.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the cache subsystem testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --timescale 1ns/1ps \
    --top-module tb_cache_subsystem \
    -Mdir obj_dir \
    -f list.f
status=$?
if [ $status -ne 0 ]; then
    echo "build failed with status $status"
    exit 1
fi

./obj_dir/Vtb_cache_subsystem
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
    exit 1
fi
exit 0

//--- verification/tb_cache_subsystem.sv
/*
 * testbench for the cache subsystem with directed tests checked against
 * a shadow memory and a shadow tag table
 */
module tb_cache_subsystem
    import dcache_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    // about 300 operations at the worst miss of 17 cycles plus margin
    localparam int TIMEOUT_CYCLES = 20000;
    localparam int RANDOM_OPS     = 250;

    logic                    clk;
    logic                    rst_n;
    logic [NUM_RD_PORTS-1:0] rd_req;
    addr_t                   rd_addr [NUM_RD_PORTS];
    word_t                   rd_data [NUM_RD_PORTS];
    logic [NUM_RD_PORTS-1:0] rd_ack;
    logic [NUM_RD_PORTS-1:0] rd_hit;
    logic                    wr_req;
    addr_t                   wr_addr;
    word_t                   wr_data;
    logic                    wr_ack;
    logic                    wr_hit;

    // reference models
    word_t                shadow_mem [2**ADDR_W];
    tag_t                 shadow_tag [NUM_LINES];
    logic [NUM_LINES-1:0] shadow_valid;
    int                   cycle_count = 0;

    cache_subsystem u_cache_subsystem (
        .clk     (clk),
        .rst_n   (rst_n),
        .rd_req  (rd_req),
        .rd_addr (rd_addr),
        .rd_data (rd_data),
        .rd_ack  (rd_ack),
        .rd_hit  (rd_hit),
        .wr_req  (wr_req),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .wr_ack  (wr_ack),
        .wr_hit  (wr_hit)
    );

    initial begin
        clk = 1'b0;
    end

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Checks failed");
            $fatal(1, "simulation stopped by the cycle limit");
        end
    end

    function automatic addr_t make_addr(input tag_t tag, input index_t index,
                                        input offset_t offset);
        return {tag, index, offset};
    endfunction

    // hit expected when the table already holds the line
    function automatic logic line_present(input addr_t addr);
        index_t idx;
        idx = addr[OFFSET_W +: INDEX_W];
        return shadow_valid[idx] && (shadow_tag[idx] == addr[ADDR_W-1 -: TAG_W]);
    endfunction

    // every access leaves its line valid with its tag
    function automatic void note_access(input addr_t addr);
        shadow_valid[addr[OFFSET_W +: INDEX_W]] = 1'b1;
        shadow_tag[addr[OFFSET_W +: INDEX_W]]   = addr[ADDR_W-1 -: TAG_W];
    endfunction

    task automatic check_word(input word_t got, input word_t exp, input string what);
        if (got !== exp) begin
            $display("MISMATCH at %0d ns: %s data %h, expected %h", $time, what, got, exp);
            $display("Checks failed");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    task automatic check_hit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("MISMATCH at %0d ns: %s hit %b, expected %b", $time, what, got, exp);
            $display("Checks failed");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    task automatic do_read(input int port, input addr_t addr);
        logic  exp_hit;
        word_t got_data;
        logic  got_hit;
        exp_hit = line_present(addr);
        rd_addr[port] = addr;
        rd_req[port]  = 1'b1;
        do begin
            @(posedge clk);
            #1;
        end while (!rd_ack[port]);
        got_data = rd_data[port];
        got_hit  = rd_hit[port];
        // request stays up through the ack cycle
        @(posedge clk);
        #1;
        rd_req[port] = 1'b0;
        note_access(addr);
        check_word(got_data, shadow_mem[addr], $sformatf("read port %0d addr %h", port, addr));
        check_hit(got_hit, exp_hit, $sformatf("read port %0d addr %h", port, addr));
    endtask

    task automatic do_write(input addr_t addr, input word_t data);
        logic exp_hit;
        logic got_hit;
        exp_hit = line_present(addr);
        wr_addr = addr;
        wr_data = data;
        wr_req  = 1'b1;
        do begin
            @(posedge clk);
            #1;
        end while (!wr_ack);
        got_hit = wr_hit;
        @(posedge clk);
        #1;
        wr_req = 1'b0;
        shadow_mem[addr] = data;
        note_access(addr);
        check_hit(got_hit, exp_hit, $sformatf("write addr %h", addr));
    endtask

    // both read ports at once with port 0 first in the table
    task automatic do_dual_read(input addr_t addr0, input addr_t addr1);
        logic [1:0] exp_hit;
        logic [1:0] got_hit;
        logic [1:0] seen;
        word_t      got_data [NUM_RD_PORTS];
        exp_hit[0] = line_present(addr0);
        note_access(addr0);
        exp_hit[1] = line_present(addr1);
        note_access(addr1);
        rd_addr[0] = addr0;
        rd_addr[1] = addr1;
        rd_req     = 2'b11;
        seen       = 2'b00;
        while (seen != 2'b11) begin
            @(posedge clk);
            #1;
            for (int p = 0; p < NUM_RD_PORTS; p++) begin
                if (seen[p]) begin
                    rd_req[p] = 1'b0;
                end else if (rd_ack[p]) begin
                    got_data[p] = rd_data[p];
                    got_hit[p]  = rd_hit[p];
                    seen[p]     = 1'b1;
                end
            end
        end
        @(posedge clk);
        #1;
        rd_req = '0;
        check_word(got_data[0], shadow_mem[addr0], $sformatf("dual read port 0 addr %h", addr0));
        check_hit(got_hit[0], exp_hit[0], $sformatf("dual read port 0 addr %h", addr0));
        check_word(got_data[1], shadow_mem[addr1], $sformatf("dual read port 1 addr %h", addr1));
        check_hit(got_hit[1], exp_hit[1], $sformatf("dual read port 1 addr %h", addr1));
    endtask

    task automatic test_after_reset();
        do_read(0, make_addr(6'd1, 4'd0, 2'd0));
        do_read(0, make_addr(6'd1, 4'd0, 2'd2));
        do_read(1, make_addr(6'd2, 4'd1, 2'd1));
        do_read(1, make_addr(6'd2, 4'd1, 2'd3));
    endtask

    task automatic test_write_allocate();
        do_write(make_addr(6'd3, 4'd4, 2'd0), 32'hcafe_0001);
        do_write(make_addr(6'd3, 4'd4, 2'd1), 32'h1234_5678);
        do_read(0, make_addr(6'd3, 4'd4, 2'd0));
        do_read(1, make_addr(6'd3, 4'd4, 2'd1));
    endtask

    task automatic test_dual_reads();
        do_dual_read(make_addr(6'd2, 4'd8, 2'd0), make_addr(6'd2, 4'd8, 2'd3));
        do_dual_read(make_addr(6'd4, 4'd9, 2'd1), make_addr(6'd5, 4'd10, 2'd2));
        do_dual_read(make_addr(6'd3, 4'd4, 2'd1), make_addr(6'd3, 4'd4, 2'd0));
    endtask

    // same index with another tag forces the written line out
    task automatic test_dirty_eviction();
        do_write(make_addr(6'd5, 4'd3, 2'd1), 32'hdead_beef);
        do_read(0, make_addr(6'd9, 4'd3, 2'd2));
        do_read(1, make_addr(6'd5, 4'd3, 2'd1));
    endtask

    task automatic test_random_mix();
        int    op;
        addr_t addr;
        for (int i = 0; i < RANDOM_OPS; i++) begin
            op   = $urandom_range(2, 0);
            addr = make_addr(tag_t'($urandom_range(7, 0)), index_t'($urandom_range(15, 0)),
                             offset_t'($urandom_range(3, 0)));
            if (op == 2) begin
                do_write(addr, $urandom);
            end else begin
                do_read(op, addr);
            end
        end
    endtask

    initial begin
        void'($urandom(57527));
        rst_n      = 1'b0;
        rd_req     = '0;
        rd_addr[0] = '0;
        rd_addr[1] = '0;
        wr_req     = 1'b0;
        wr_addr    = '0;
        wr_data    = '0;
        for (int i = 0; i < 2**ADDR_W; i++) begin
            shadow_mem[i] = '0;
        end
        for (int i = 0; i < NUM_LINES; i++) begin
            shadow_tag[i] = '0;
        end
        shadow_valid = '0;
        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;
        test_after_reset();
        test_write_allocate();
        test_dual_reads();
        test_dirty_eviction();
        test_random_mix();
        $display("All checks passed");
        $finish;
    end

endmodule

//--- src/cache_subsystem.sv
/*
 * cache subsystem top, data cache and miss controller over word-wide main memory
 */
module cache_subsystem
    import dcache_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [NUM_RD_PORTS-1:0] rd_req,
    input  addr_t                   rd_addr [NUM_RD_PORTS],
    output word_t                   rd_data [NUM_RD_PORTS],
    output logic [NUM_RD_PORTS-1:0] rd_ack,
    output logic [NUM_RD_PORTS-1:0] rd_hit,
    input  logic                    wr_req,
    input  addr_t                   wr_addr,
    input  word_t                   wr_data,
    output logic                    wr_ack,
    output logic                    wr_hit
);

    // cache to miss controller
    logic    fill_start;
    index_t  fill_index;
    tag_t    fill_tag;
    logic    evict_dirty;
    tag_t    evict_tag;
    word_t   evict_line_data [LINE_WORDS];
    logic    fill_we;
    offset_t fill_offset;
    word_t   fill_word;
    logic    fill_done;
    logic    busy;

    // Wishbone
    logic  wb_cyc;
    logic  wb_stb;
    logic  wb_we;
    addr_t wb_adr;
    word_t wb_dat_w;
    word_t wb_dat_r;
    logic  wb_ack;

    data_cache u_data_cache (
        .clk             (clk),
        .rst_n           (rst_n),
        .rd_req          (rd_req),
        .rd_addr         (rd_addr),
        .rd_data         (rd_data),
        .rd_ack          (rd_ack),
        .rd_hit          (rd_hit),
        .wr_req          (wr_req),
        .wr_addr         (wr_addr),
        .wr_data         (wr_data),
        .wr_ack          (wr_ack),
        .wr_hit          (wr_hit),
        .fill_start      (fill_start),
        .fill_index      (fill_index),
        .fill_tag        (fill_tag),
        .evict_dirty     (evict_dirty),
        .evict_tag       (evict_tag),
        .evict_line_data (evict_line_data),
        .fill_we         (fill_we),
        .fill_offset     (fill_offset),
        .fill_word       (fill_word),
        .fill_done       (fill_done),
        .busy            (busy)
    );

    cache_miss_ctrl u_miss_ctrl (
        .clk             (clk),
        .rst_n           (rst_n),
        .fill_start      (fill_start),
        .fill_index      (fill_index),
        .fill_tag        (fill_tag),
        .evict_dirty     (evict_dirty),
        .evict_tag       (evict_tag),
        .evict_line_data (evict_line_data),
        .fill_we         (fill_we),
        .fill_offset     (fill_offset),
        .fill_word       (fill_word),
        .fill_done       (fill_done),
        .busy            (busy),
        .wb_cyc          (wb_cyc),
        .wb_stb          (wb_stb),
        .wb_we           (wb_we),
        .wb_adr          (wb_adr),
        .wb_dat_w        (wb_dat_w),
        .wb_dat_r        (wb_dat_r),
        .wb_ack          (wb_ack)
    );

    main_memory u_main_memory (
        .clk      (clk),
        .rst_n    (rst_n),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack)
    );

endmodule

//--- src/main_memory.sv
/*
 * main memory, Wishbone classic slave of 4096 words with a one-cycle ack
 */
module main_memory
    import dcache_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  logic  wb_cyc,
    input  logic  wb_stb,
    input  logic  wb_we,
    input  addr_t wb_adr,
    input  word_t wb_dat_w,
    output word_t wb_dat_r,
    output logic  wb_ack
);

    word_t mem [2**ADDR_W];
    logic  access;

    initial begin
        for (int i = 0; i < 2**ADDR_W; i++) begin
            mem[i] = '0;
        end
    end

    // no new access in the ack cycle, so a held strobe is served once
    assign access = wb_cyc && wb_stb && !wb_ack;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= access;
        end
    end

    always @(posedge clk) begin
        if (access) begin
            if (wb_we) begin
                mem[wb_adr] <= wb_dat_w;
            end else begin
                wb_dat_r <= mem[wb_adr];
            end
        end
    end

    // master keeps the cycle open until it sees the ack
    a_ack_in_cyc: assert property (@(posedge clk) disable iff (!rst_n)
        wb_ack |-> wb_cyc);

endmodule

//--- data_cache/data_cache.sv
/*
 * direct-mapped write-back data cache, two read ports and one write port,
 * hit service per port and selection of the miss handed to the miss controller
 */
module data_cache
    import dcache_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [NUM_RD_PORTS-1:0] rd_req,
    input  addr_t                   rd_addr [NUM_RD_PORTS],
    output word_t                   rd_data [NUM_RD_PORTS],
    output logic [NUM_RD_PORTS-1:0] rd_ack,
    output logic [NUM_RD_PORTS-1:0] rd_hit,
    input  logic                    wr_req,
    input  addr_t                   wr_addr,
    input  word_t                   wr_data,
    output logic                    wr_ack,
    output logic                    wr_hit,
    output logic                    fill_start,
    output index_t                  fill_index,
    output tag_t                    fill_tag,
    output logic                    evict_dirty,
    output tag_t                    evict_tag,
    output word_t                   evict_line_data [LINE_WORDS],
    input  logic                    fill_we,
    input  offset_t                 fill_offset,
    input  word_t                   fill_word,
    input  logic                    fill_done,
    input  logic                    busy
);

    tag_t                 tag_mem [NUM_LINES];
    word_t                data_mem [NUM_LINES][LINE_WORDS];
    logic [NUM_LINES-1:0] valid;
    logic [NUM_LINES-1:0] dirty;

    // port NUM_RD_PORTS is the write port
    logic [NUM_RD_PORTS:0] req;
    logic [NUM_RD_PORTS:0] ack;
    logic [NUM_RD_PORTS:0] line_hit;
    logic [NUM_RD_PORTS:0] miss;
    logic [NUM_RD_PORTS:0] serve;
    logic [NUM_RD_PORTS:0] stalled;
    addr_t                 addr     [NUM_RD_PORTS+1];
    tag_t                  p_tag    [NUM_RD_PORTS+1];
    index_t                p_index  [NUM_RD_PORTS+1];
    offset_t               p_offset [NUM_RD_PORTS+1];

    logic       start_now;
    logic [1:0] sel_port;
    index_t     sel_index;

    assign req = {wr_req, rd_req};
    assign ack = {wr_ack, rd_ack};

    always_comb begin
        for (int p = 0; p < NUM_RD_PORTS; p++) begin
            addr[p] = rd_addr[p];
        end
        addr[NUM_RD_PORTS] = wr_addr;
    end

    // split, tag compare, and miss detection per port
    always_comb begin
        for (int p = 0; p <= NUM_RD_PORTS; p++) begin
            p_tag[p]    = addr[p][ADDR_W-1 -: TAG_W];
            p_index[p]  = addr[p][OFFSET_W +: INDEX_W];
            p_offset[p] = addr[p][OFFSET_W-1:0];
            line_hit[p] = valid[p_index[p]] && (tag_mem[p_index[p]] == p_tag[p]);
            miss[p]     = req[p] && !ack[p] && !line_hit[p] && !stalled[p];
        end
    end

    // one miss at a time, not before the last stalled port has replayed
    assign start_now = (|miss) && !(|stalled) && !busy;

    // lowest port number wins
    always_comb begin
        sel_port = '0;
        for (int p = NUM_RD_PORTS; p >= 0; p--) begin
            if (miss[p]) begin
                sel_port = 2'(p);
            end
        end
    end

    assign sel_index = p_index[sel_port];

    // a line about to be evicted takes no hit in the same edge
    // the stalled port replays in the fill_done cycle
    always_comb begin
        for (int p = 0; p <= NUM_RD_PORTS; p++) begin
            serve[p] = req[p] && !ack[p] &&
                       ((line_hit[p] && !(start_now && p_index[p] == sel_index)) ||
                        (fill_done && stalled[p]));
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid      <= '0;
            dirty      <= '0;
            stalled    <= '0;
            rd_ack     <= '0;
            rd_hit     <= '0;
            wr_ack     <= 1'b0;
            wr_hit     <= 1'b0;
            fill_start <= 1'b0;
        end else begin
            fill_start <= start_now;
            if (start_now) begin
                stalled[sel_port] <= 1'b1;
                valid[sel_index]  <= 1'b0;
            end
            if (fill_done) begin
                valid[fill_index] <= 1'b1;
                dirty[fill_index] <= 1'b0;
            end
            // a replayed write lands after the clear above
            if (serve[NUM_RD_PORTS]) begin
                dirty[p_index[NUM_RD_PORTS]] <= 1'b1;
            end
            for (int p = 0; p <= NUM_RD_PORTS; p++) begin
                if (serve[p]) begin
                    stalled[p] <= 1'b0;
                end
            end
            rd_ack <= serve[NUM_RD_PORTS-1:0];
            rd_hit <= ~stalled[NUM_RD_PORTS-1:0];
            wr_ack <= serve[NUM_RD_PORTS];
            wr_hit <= !stalled[NUM_RD_PORTS];
        end
    end

    always_ff @(posedge clk) begin
        if (start_now) begin
            fill_index      <= sel_index;
            fill_tag        <= p_tag[sel_port];
            evict_dirty     <= valid[sel_index] && dirty[sel_index];
            evict_tag       <= tag_mem[sel_index];
            evict_line_data <= data_mem[sel_index];
        end
        if (fill_we) begin
            data_mem[fill_index][fill_offset] <= fill_word;
        end
        if (fill_done) begin
            tag_mem[fill_index] <= fill_tag;
        end
        for (int p = 0; p < NUM_RD_PORTS; p++) begin
            if (serve[p]) begin
                rd_data[p] <= data_mem[p_index[p]][p_offset[p]];
            end
        end
        if (serve[NUM_RD_PORTS]) begin
            data_mem[p_index[NUM_RD_PORTS]][p_offset[NUM_RD_PORTS]] <= wr_data;
        end
    end

    // requester holds its request through the ack cycle
    a_ack_has_req: assert property (@(posedge clk) disable iff (!rst_n)
        (ack & ~req) == '0);

    a_no_start_busy: assert property (@(posedge clk) disable iff (!rst_n)
        fill_start |-> !busy);

endmodule

//--- data_cache/cache_miss_ctrl.sv
/*
 * miss controller, a Wishbone classic master that writes back a dirty victim
 * and refills the line one word at a time
 */
module cache_miss_ctrl
    import dcache_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  logic    fill_start,
    input  index_t  fill_index,
    input  tag_t    fill_tag,
    input  logic    evict_dirty,
    input  tag_t    evict_tag,
    input  word_t   evict_line_data [LINE_WORDS],
    output logic    fill_we,
    output offset_t fill_offset,
    output word_t   fill_word,
    output logic    fill_done,
    output logic    busy,
    output logic    wb_cyc,
    output logic    wb_stb,
    output logic    wb_we,
    output addr_t   wb_adr,
    output word_t   wb_dat_w,
    input  word_t   wb_dat_r,
    input  logic    wb_ack
);

    typedef enum logic [1:0] {
        st_idle,
        st_write_back,
        st_refill,
        st_done
    } state_t;

    state_t  state;
    offset_t word_cnt;
    offset_t next_cnt;
    index_t  line_index;
    tag_t    new_tag;
    word_t   line_buf [LINE_WORDS];
    logic    last_word;

    assign next_cnt  = word_cnt + 1'b1;
    assign last_word = (word_cnt == offset_t'(LINE_WORDS - 1));
    assign busy      = (state != st_idle);

    // refill words go straight to the cache as the slave acks them
    assign fill_we     = (state == st_refill) && wb_ack;
    assign fill_offset = word_cnt;
    assign fill_word   = wb_dat_r;
    assign fill_done   = (state == st_done);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= st_idle;
            word_cnt <= '0;
            wb_cyc   <= 1'b0;
            wb_stb   <= 1'b0;
            wb_we    <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (fill_start) begin
                        word_cnt <= '0;
                        wb_cyc   <= 1'b1;
                        wb_stb   <= 1'b1;
                        wb_we    <= evict_dirty;
                        state    <= evict_dirty ? st_write_back : st_refill;
                    end
                end
                st_write_back: begin
                    if (wb_ack) begin
                        word_cnt <= next_cnt;
                        if (last_word) begin
                            wb_we <= 1'b0;
                            state <= st_refill;
                        end
                    end
                end
                st_refill: begin
                    if (wb_ack) begin
                        word_cnt <= next_cnt;
                        if (last_word) begin
                            wb_cyc <= 1'b0;
                            wb_stb <= 1'b0;
                            state  <= st_done;
                        end
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // victim snapshot and bus address, advanced on each ack
    always_ff @(posedge clk) begin
        if (state == st_idle && fill_start) begin
            line_buf   <= evict_line_data;
            line_index <= fill_index;
            new_tag    <= fill_tag;
            wb_dat_w   <= evict_line_data[0];
            wb_adr     <= evict_dirty ? {evict_tag, fill_index, offset_t'(0)}
                                      : {fill_tag, fill_index, offset_t'(0)};
        end else if (wb_ack) begin
            wb_dat_w <= line_buf[next_cnt];
            if (state == st_write_back && last_word) begin
                wb_adr <= {new_tag, line_index, offset_t'(0)};
            end else begin
                wb_adr <= {wb_adr[ADDR_W-1:OFFSET_W], next_cnt};
            end
        end
    end

    a_stb_in_cyc: assert property (@(posedge clk) disable iff (!rst_n)
        wb_stb |-> wb_cyc);

endmodule

//--- common/dcache_pkg.sv
/*
 * data cache shared definitions: address split, word and line sizes, common types
 */
package dcache_pkg;

    // data word and word address
    localparam int WORD_W = 32;
    localparam int ADDR_W = 12;

    // address split, tag | index | offset
    localparam int OFFSET_W = 2;
    localparam int INDEX_W  = 4;
    localparam int TAG_W    = ADDR_W - INDEX_W - OFFSET_W;

    // cache geometry
    localparam int LINE_WORDS = 1 << OFFSET_W;
    localparam int NUM_LINES  = 1 << INDEX_W;

    // core side, the write port comes after the read ports
    localparam int NUM_RD_PORTS = 2;

    typedef logic [WORD_W-1:0]   word_t;
    typedef logic [ADDR_W-1:0]   addr_t;
    typedef logic [TAG_W-1:0]    tag_t;
    typedef logic [INDEX_W-1:0]  index_t;
    typedef logic [OFFSET_W-1:0] offset_t;

endpackage
